// ==== dnc_settings.svh ====
////////////////////
// Fixed-point widths, read head count, location count width
// and location pipeline depth for the usage update
////////////////////

`ifndef DNC_SETTINGS_SVH
`define DNC_SETTINGS_SVH

// Q0.16 values
`define DNC_FIX_WIDTH 16
`define DNC_FRAC_BITS 16
// Signed Q8.8 logits
`define DNC_LOGIT_WIDTH 16
// Read heads, location counter, location strobe to usage strobe
`define DNC_R_MAX 4
`define DNC_N_WIDTH 16
`define DNC_PIPE_DEPTH 3

`endif

// ==== dnc_pkg.sv ====
////////////////////
// Fixed-point, logit, gate and location types
// Q0.16 product, complement and saturating add
////////////////////

`include "dnc_settings.svh"

package dnc_pkg;

  // Unsigned Q0.16, all ones is full scale
  typedef logic [`DNC_FIX_WIDTH-1:0] fix_t;
  // Signed Q8.8
  typedef logic signed [`DNC_LOGIT_WIDTH-1:0] logit_t;

  typedef logic [$clog2(`DNC_R_MAX)-1:0] head_idx_t;
  typedef logic [`DNC_R_MAX-1:0] head_mask_t;
  // One free gate per read head
  typedef fix_t [`DNC_R_MAX-1:0] gate_vec_t;

  // Inputs of one memory location
  typedef struct packed {
    fix_t [`DNC_R_MAX-1:0] w_read;
    fix_t w_write;
    fix_t usage_prev;
  } loc_in_t;

  // Retention result with the usage operands
  typedef struct packed {
    fix_t psi;
    fix_t w_write;
    fix_t usage_prev;
  } ret_t;

  // Full product, drop the fraction bits, truncate
  function automatic fix_t fix_mul(input fix_t a, input fix_t b);
    logic [2*`DNC_FIX_WIDTH-1:0] full;
    full = a * b;
    return full[`DNC_FRAC_BITS +: `DNC_FIX_WIDTH];
  endfunction

  // All ones minus v is the bitwise inverse
  function automatic fix_t fix_one_minus(input fix_t v);
    return ~v;
  endfunction

  // Sum clamps at full scale
  function automatic fix_t fix_add_sat(input fix_t a, input fix_t b);
    logic [`DNC_FIX_WIDTH:0] sum;
    sum = a + b;
    return sum[`DNC_FIX_WIDTH] ? '1 : sum[`DNC_FIX_WIDTH-1:0];
  endfunction

endpackage

// ==== dnc_free_gates.sv ====
////////////////////
// Free gates: hard sigmoid of the logit stream
// Gate register file, one slot per read head
////////////////////

`timescale 1ns/10ps

`include "dnc_settings.svh"

module dnc_free_gates (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               gate_write,
  input  dnc_pkg::head_idx_t gate_index,
  input  dnc_pkg::logit_t    f_in,
  output logic               f_out_enable,
  output dnc_pkg::fix_t      f_out,
  output dnc_pkg::gate_vec_t gate_vec
);

  import dnc_pkg::*;

  // Room for the logit shifted by 5 plus the offset
  localparam int SIG_W = `DNC_LOGIT_WIDTH + 8;

  // 0.5 + x/8 in code units is 32768 + 32 x, clamped
  function automatic fix_t hard_sigmoid(input logit_t x);
    logic signed [SIG_W-1:0] ext;
    logic signed [SIG_W-1:0] acc;
    ext = {{(SIG_W-`DNC_LOGIT_WIDTH){x[`DNC_LOGIT_WIDTH-1]}}, x};
    acc = (ext <<< 5) + SIG_W'(32768);
    if (acc[SIG_W-1]) begin
      return '0;
    end else if (acc > SIG_W'(65535)) begin
      return '1;
    end else begin
      return acc[`DNC_FIX_WIDTH-1:0];
    end
  endfunction

  gate_vec_t gate_q;
  fix_t      gate_c;

  assign gate_c = hard_sigmoid(f_in);

  ////////////////////
  // Gate slots
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gate_q <= '0;
    end else if (gate_write) begin
      gate_q[gate_index] <= gate_c;
    end
  end

  // Strobe follows the write by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      f_out_enable <= 1'b0;
    end else begin
      f_out_enable <= gate_write;
    end
  end

  // Echo of the gate just written
  always_ff @(posedge clk) begin
    if (gate_write) begin
      f_out <= gate_c;
    end
  end

  assign gate_vec = gate_q;

endmodule

// ==== dnc_retention_vector.sv ====
////////////////////
// Retention vector psi per memory location
// Stage A per-head terms, stage B ordered product
////////////////////

`timescale 1ns/10ps

`include "dnc_settings.svh"

module dnc_retention_vector (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                loc_valid,
  input  dnc_pkg::loc_in_t    loc_in,
  input  dnc_pkg::head_mask_t head_mask,
  input  dnc_pkg::gate_vec_t  gate_vec,
  output logic                ret_valid,
  output dnc_pkg::ret_t       ret_data
);

  import dnc_pkg::*;

  // Stage A registers
  fix_t [`DNC_R_MAX-1:0] term_a;
  fix_t                  w_write_a;
  fix_t                  usage_prev_a;
  head_mask_t            mask_a;
  logic                  valid_a;

  // Stage B product chain
  fix_t psi_c;

  ////////////////////
  // Valid bits
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_a   <= 1'b0;
      ret_valid <= 1'b0;
    end else begin
      valid_a   <= loc_valid;
      ret_valid <= valid_a;
    end
  end

  ////////////////////
  // Stage A
  ////////////////////

  // Term per head is 1 - f(i) * w_read(i)
  always_ff @(posedge clk) begin
    if (loc_valid) begin
      for (int i = 0; i < `DNC_R_MAX; i++) begin
        term_a[i] <= fix_one_minus(fix_mul(gate_vec[i], loc_in.w_read[i]));
      end
      w_write_a    <= loc_in.w_write;
      usage_prev_a <= loc_in.usage_prev;
      // Mask travels with its location
      mask_a       <= head_mask;
    end
  end

  ////////////////////
  // Stage B
  ////////////////////

  // Chain from full scale, heads folded in order 0 upward
  always_comb begin
    psi_c = '1;
    for (int i = 0; i < `DNC_R_MAX; i++) begin
      // Inactive head passes the chain through
      if (mask_a[i]) begin
        psi_c = fix_mul(psi_c, term_a[i]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid_a) begin
      ret_data.psi        <= psi_c;
      ret_data.w_write    <= w_write_a;
      ret_data.usage_prev <= usage_prev_a;
    end
  end

endmodule

// ==== dnc_usage_vector.sv ====
////////////////////
// Usage update
// u = (u_prev + w_w - u_prev * w_w) * psi
////////////////////

`timescale 1ns/10ps

module dnc_usage_vector (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          ret_valid,
  input  dnc_pkg::ret_t ret_data,
  output logic          usage_out_enable,
  output dnc_pkg::fix_t usage_out
);

  import dnc_pkg::*;

  fix_t sum_c;
  fix_t prod_c;
  fix_t diff_c;
  fix_t usage_c;

  always_comb begin
    // Add clamps at full scale
    sum_c   = fix_add_sat(ret_data.usage_prev, ret_data.w_write);
    prod_c  = fix_mul(ret_data.usage_prev, ret_data.w_write);
    // Subtract clamps at zero
    diff_c  = (sum_c > prod_c) ? sum_c - prod_c : '0;
    // Retention scales the result
    usage_c = fix_mul(diff_c, ret_data.psi);
  end

  ////////////////////
  // Output register
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      usage_out_enable <= 1'b0;
    end else begin
      usage_out_enable <= ret_valid;
    end
  end

  // Value only moves with a valid result
  always_ff @(posedge clk) begin
    if (ret_valid) begin
      usage_out <= usage_c;
    end
  end

endmodule

// ==== dnc_alloc_control.sv ====
////////////////////
// Phase control for the usage update
// Gate, location and drain phases, counters, head mask
////////////////////

`timescale 1ns/10ps

`include "dnc_settings.svh"

module dnc_alloc_control (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           start,
  output logic                           ready,
  input  logic [$clog2(`DNC_R_MAX):0]    size_r,
  input  logic [`DNC_N_WIDTH-1:0]        size_n,
  input  logic                           f_in_enable,
  input  logic                           loc_in_enable,
  output logic                           gate_write,
  output dnc_pkg::head_idx_t             gate_index,
  output logic                           loc_valid,
  output dnc_pkg::head_mask_t            head_mask,
  input  logic                           usage_done_strobe
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_GATES,
    ST_LOCS,
    ST_DRAIN
  } state_t;

  state_t state;

  // Sizes latched at start
  logic [$clog2(`DNC_R_MAX):0] size_r_q;
  logic [`DNC_N_WIDTH-1:0]     size_n_q;

  // Accepted locations and returned usages
  logic [`DNC_N_WIDTH-1:0] loc_cnt;
  logic [`DNC_N_WIDTH-1:0] use_cnt;

  logic [$clog2(`DNC_R_MAX):0] r_last;
  logic [`DNC_N_WIDTH-1:0]     n_last;
  logic                        last_gate;
  logic                        last_loc;
  logic                        last_use;

  assign r_last    = size_r_q - 1'b1;
  assign n_last    = size_n_q - 1'b1;
  assign last_gate = ({1'b0, gate_index} == r_last);
  assign last_loc  = (loc_cnt == n_last);
  assign last_use  = (use_cnt == n_last);

  ////////////////////
  // Strobe qualification
  ////////////////////

  assign ready      = (state == ST_IDLE);
  // Strobes outside their phase drop here
  assign gate_write = f_in_enable && (state == ST_GATES);
  assign loc_valid  = loc_in_enable && (state == ST_LOCS);

  // Heads below the latched count are active
  always_comb begin
    for (int i = 0; i < `DNC_R_MAX; i++) begin
      head_mask[i] = (i < size_r_q);
    end
  end

  ////////////////////
  // Phase FSM
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= ST_IDLE;
      size_r_q   <= '0;
      size_n_q   <= '0;
      gate_index <= '0;
      loc_cnt    <= '0;
      use_cnt    <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state      <= ST_GATES;
            size_r_q   <= size_r;
            size_n_q   <= size_n;
            gate_index <= '0;
            loc_cnt    <= '0;
            use_cnt    <= '0;
          end
        end
        ST_GATES: begin
          // Heads arrive in order 0 upward
          if (gate_write) begin
            gate_index <= gate_index + 1'b1;
            if (last_gate) begin
              state <= ST_LOCS;
            end
          end
        end
        ST_LOCS: begin
          if (loc_valid) begin
            loc_cnt <= loc_cnt + 1'b1;
            if (last_loc) begin
              state <= ST_DRAIN;
            end
          end
        end
        ST_DRAIN: begin
          // Ready rises the cycle after the last usage
          if (usage_done_strobe && last_use) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
      // Usages can return while locations still arrive
      if (usage_done_strobe && state != ST_IDLE) begin
        use_cnt <= use_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== dnc_usage_top.sv ====
////////////////////
// Usage update top level
// Control, free gates, retention and usage blocks
////////////////////

`timescale 1ns/10ps

`include "dnc_settings.svh"

module dnc_usage_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start,
  output logic                        ready,
  input  logic [$clog2(`DNC_R_MAX):0] size_r,
  input  logic [`DNC_N_WIDTH-1:0]     size_n,
  input  logic                        f_in_enable,
  input  dnc_pkg::logit_t             f_in,
  output logic                        f_out_enable,
  output dnc_pkg::fix_t               f_out,
  input  logic                        loc_in_enable,
  input  dnc_pkg::loc_in_t            loc_in,
  output logic                        usage_out_enable,
  output dnc_pkg::fix_t               usage_out
);

  import dnc_pkg::*;

  // Control to datapath
  logic       gate_write;
  head_idx_t  gate_index;
  logic       loc_valid;
  head_mask_t head_mask;

  // Between datapath stages
  gate_vec_t  gate_vec;
  logic       ret_valid;
  ret_t       ret_data;

  dnc_alloc_control i_dnc_alloc_control (
    .clk               (clk),
    .rst_n             (rst_n),
    .start             (start),
    .ready             (ready),
    .size_r            (size_r),
    .size_n            (size_n),
    .f_in_enable       (f_in_enable),
    .loc_in_enable     (loc_in_enable),
    .gate_write        (gate_write),
    .gate_index        (gate_index),
    .loc_valid         (loc_valid),
    .head_mask         (head_mask),
    .usage_done_strobe (usage_out_enable)
  );

  dnc_free_gates i_dnc_free_gates (
    .clk          (clk),
    .rst_n        (rst_n),
    .gate_write   (gate_write),
    .gate_index   (gate_index),
    .f_in         (f_in),
    .f_out_enable (f_out_enable),
    .f_out        (f_out),
    .gate_vec     (gate_vec)
  );

  // Location data comes straight from the inputs
  dnc_retention_vector i_dnc_retention_vector (
    .clk       (clk),
    .rst_n     (rst_n),
    .loc_valid (loc_valid),
    .loc_in    (loc_in),
    .head_mask (head_mask),
    .gate_vec  (gate_vec),
    .ret_valid (ret_valid),
    .ret_data  (ret_data)
  );

  dnc_usage_vector i_dnc_usage_vector (
    .clk              (clk),
    .rst_n            (rst_n),
    .ret_valid        (ret_valid),
    .ret_data         (ret_data),
    .usage_out_enable (usage_out_enable),
    .usage_out        (usage_out)
  );

endmodule

// ==== dnc_usage_tb.sv ====
////////////////////
// Testbench for the usage update top level
// Clock, reset, LFSR stimulus, reference model
// Compare tasks, latency checks and the verdict
////////////////////

`timescale 1ns/10ps

`include "dnc_settings.svh"

module dnc_usage_tb;

  import dnc_pkg::*;

  localparam int TIMEOUT = 200;

  logic        clk;
  logic        rst_n;
  logic        start;
  logic        ready;
  logic [2:0]  size_r;
  logic [15:0] size_n;
  logic        f_in_enable;
  logit_t      f_in;
  logic        f_out_enable;
  fix_t        f_out;
  logic        loc_in_enable;
  loc_in_t     loc_in;
  logic        usage_out_enable;
  fix_t        usage_out;

  // Expected values with the cycle they are due in
  fix_t  gate_exp_q[$];
  int    gate_cyc_q[$];
  fix_t  use_exp_q[$];
  int    use_cyc_q[$];
  int    cycle;
  int    last_use_cycle;
  string test_name;
  logic [31:0] lfsr_state = 32'heac9_b8de;
  gate_vec_t   model_gates;
  logit_t      logit_set [4];

  dnc_usage_top i_dnc_usage_top (
    .clk              (clk),
    .rst_n            (rst_n),
    .start            (start),
    .ready            (ready),
    .size_r           (size_r),
    .size_n           (size_n),
    .f_in_enable      (f_in_enable),
    .f_in             (f_in),
    .f_out_enable     (f_out_enable),
    .f_out            (f_out),
    .loc_in_enable    (loc_in_enable),
    .loc_in           (loc_in),
    .usage_out_enable (usage_out_enable),
    .usage_out        (usage_out)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  ////////////////////
  // Random numbers
  ////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function logic next_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  // Edge mode favours zero and full scale
  function automatic fix_t pick_value(input bit edges);
    logic [1:0] sel;
    sel = edges ? rand_bits(2) : 2'd3;
    case (sel)
      2'd0: return 16'h0000;
      2'd1: return 16'hffff;
      default: return rand_bits(16);
    endcase
  endfunction

  function automatic loc_in_t random_loc(input bit edges);
    loc_in_t l;
    for (int h = 0; h < `DNC_R_MAX; h++) begin
      l.w_read[h] = pick_value(edges);
    end
    l.w_write    = pick_value(edges);
    l.usage_prev = pick_value(edges);
    return l;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  function automatic fix_t q16_mul(input fix_t a, input fix_t b);
    logic [31:0] p;
    p = 32'(a) * 32'(b);
    return fix_t'(p >> 16);
  endfunction

  function automatic fix_t sat_add(input fix_t a, input fix_t b);
    int s;
    s = int'(a) + int'(b);
    return (s > 65535) ? 16'hffff : fix_t'(s);
  endfunction

  function automatic fix_t sat_sub(input fix_t a, input fix_t b);
    int d;
    d = int'(a) - int'(b);
    return (d < 0) ? 16'h0000 : fix_t'(d);
  endfunction

  // 0.5 + x/8 clamped to the unit range
  function automatic fix_t sigmoid_model(input logit_t x);
    int v;
    v = 32768 + 32 * int'(x);
    if (v < 0) v = 0;
    if (v > 65535) v = 65535;
    return fix_t'(v);
  endfunction

  // Only the first r heads count
  function automatic fix_t usage_model(input loc_in_t l, input gate_vec_t g, input int r);
    fix_t psi;
    fix_t t;
    psi = 16'hffff;
    for (int h = 0; h < r; h++) begin
      psi = q16_mul(psi, 16'd65535 - q16_mul(g[h], l.w_read[h]));
    end
    t = sat_add(l.usage_prev, l.w_write);
    t = sat_sub(t, q16_mul(l.usage_prev, l.w_write));
    return q16_mul(t, psi);
  endfunction

  ////////////////////
  // Checks
  ////////////////////

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_gate(input fix_t exp, input fix_t act);
    if (exp !== act) begin
      fail_stop($sformatf("mismatch %s gate: expected %h, actual %h", test_name, exp, act));
    end
  endtask

  task automatic check_usage(input fix_t exp, input fix_t act);
    if (exp !== act) begin
      fail_stop($sformatf("mismatch %s usage: expected %h, actual %h", test_name, exp, act));
    end
  endtask

  task automatic check_cycle(input int exp, input int act);
    if (exp != act) begin
      fail_stop($sformatf("mismatch %s cycle: expected %0d, actual %0d", test_name, exp, act));
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (f_out_enable) begin
        if (gate_exp_q.size() == 0) begin
          fail_stop($sformatf("%s: gate strobe with no gate expected", test_name));
        end else begin
          check_cycle(gate_cyc_q.pop_front(), cycle);
          check_gate(gate_exp_q.pop_front(), f_out);
        end
      end
      if (usage_out_enable) begin
        if (use_exp_q.size() == 0) begin
          fail_stop($sformatf("%s: usage strobe with no usage expected", test_name));
        end else begin
          check_cycle(use_cyc_q.pop_front(), cycle);
          check_usage(use_exp_q.pop_front(), usage_out);
          last_use_cycle = cycle;
        end
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic wait_ready(input string what);
    int k;
    k = 0;
    while (ready !== 1'b1) begin
      if (k == TIMEOUT) begin
        fail_stop($sformatf("%s: timeout waiting for ready %s", test_name, what));
      end else begin
        @(negedge clk);
        k++;
      end
    end
  endtask

  // Idle cycles, stray gate logits when asked
  task automatic gap_cycles(input int g, input bit stray);
    for (int i = 0; i < g; i++) begin
      f_in_enable = stray;
      f_in        = rand_bits(16);
      @(negedge clk);
    end
    f_in_enable = 1'b0;
  endtask

  task automatic run_case(input string name, input int r, input int n, input bit gaps,
                          input bit edges, input bit stray, input bit fixed_logits);
    logit_t  x;
    loc_in_t l;
    test_name = name;
    wait_ready("before start");
    start  = 1'b1;
    size_r = 3'(r);
    size_n = 16'(n);
    @(negedge clk);
    start = 1'b0;
    if (ready !== 1'b0) begin
      fail_stop($sformatf("%s: ready stayed high after start", name));
    end
    // Gate phase, heads in order
    for (int h = 0; h < r; h++) begin
      if (gaps) gap_cycles(rand_bits(2), 1'b0);
      x = fixed_logits ? logit_set[h] : logit_t'(rand_bits(16));
      f_in_enable    = 1'b1;
      f_in           = x;
      model_gates[h] = sigmoid_model(x);
      gate_exp_q.push_back(model_gates[h]);
      gate_cyc_q.push_back(cycle + 1);
      @(negedge clk);
      f_in_enable = 1'b0;
    end
    // Location phase
    for (int i = 0; i < n; i++) begin
      if (gaps) gap_cycles(rand_bits(2), stray);
      l = random_loc(edges);
      loc_in_enable = 1'b1;
      loc_in        = l;
      use_exp_q.push_back(usage_model(l, model_gates, r));
      use_cyc_q.push_back(cycle + `DNC_PIPE_DEPTH);
      @(negedge clk);
      loc_in_enable = 1'b0;
    end
    wait_ready("after drain");
    check_cycle(last_use_cycle + 1, cycle);
    if (use_exp_q.size() != 0 || gate_exp_q.size() != 0) begin
      fail_stop($sformatf("%s: ready rose with results outstanding", name));
    end
    // Location strobes while idle must do nothing
    repeat (6) begin
      loc_in_enable = next_bit();
      loc_in        = random_loc(1'b0);
      @(negedge clk);
    end
    loc_in_enable = 1'b0;
    repeat (4) @(negedge clk);
    if (ready !== 1'b1) begin
      fail_stop($sformatf("%s: idle strobes moved the control out of idle", name));
    end
  endtask

  initial begin
    rst_n         = 1'b0;
    start         = 1'b0;
    size_r        = '0;
    size_n        = '0;
    f_in_enable   = 1'b0;
    f_in          = '0;
    loc_in_enable = 1'b0;
    loc_in        = '0;
    cycle         = 0;
    last_use_cycle = 0;
    model_gates   = '0;
    test_name     = "reset";
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (ready !== 1'b1 || f_out_enable !== 1'b0 || usage_out_enable !== 1'b0) begin
      fail_stop("reset: ready low or an output strobe high after reset");
    end
    // Saturation low and high, zero, one random logit
    logit_set[0] = 16'sh8000;
    logit_set[1] = 16'sh7fff;
    logit_set[2] = 16'sh0000;
    logit_set[3] = logit_t'(rand_bits(16));
    run_case("gate_map", 4, 4, 1'b0, 1'b0, 1'b0, 1'b1);
    run_case("partial_r1", 1, 8, 1'b1, 1'b0, 1'b0, 1'b0);
    run_case("partial_r2", 2, 8, 1'b1, 1'b0, 1'b0, 1'b0);
    run_case("partial_r4", 4, 8, 1'b1, 1'b0, 1'b0, 1'b0);
    run_case("b2b_dense", 3, 20, 1'b0, 1'b0, 1'b0, 1'b0);
    run_case("b2b_gaps", 3, 20, 1'b1, 1'b0, 1'b1, 1'b0);
    // Gate 0, gate full scale, clamp points at plus and minus 4
    logit_set[0] = 16'sh8000;
    logit_set[1] = 16'sh7fff;
    logit_set[2] = 16'shfc00;
    logit_set[3] = 16'sh0400;
    run_case("edge_r1", 1, 12, 1'b0, 1'b1, 1'b0, 1'b1);
    run_case("edge_r2", 2, 12, 1'b0, 1'b1, 1'b0, 1'b1);
    run_case("edge_r4", 4, 12, 1'b1, 1'b1, 1'b1, 1'b1);
    if (gate_exp_q.size() != 0 || use_exp_q.size() != 0) begin
      fail_stop("expected results never appeared");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

// ==== sim.f ====
+incdir+.
dnc_pkg.sv
dnc_free_gates.sv
dnc_retention_vector.sv
dnc_usage_vector.sv
dnc_alloc_control.sv
dnc_usage_top.sv
dnc_usage_tb.sv
